// File: common/merge_macros.svh
`ifndef MERGE_MACROS_SVH
`define MERGE_MACROS_SVH

// entries in each record fifo
`define MERGE_FIFO_DEPTH 16

`define MERGE_KEY_W     32
`define MERGE_PAYLOAD_W 32

// stages from a take to the output fifo write
`define MERGE_PIPE_LAT 2

// occupancy count width, holds 0 to MERGE_FIFO_DEPTH
`define MERGE_COUNT_W $clog2(`MERGE_FIFO_DEPTH + 1)

`endif

// File: common/merge_pkg.sv
`include "merge_macros.svh"

package merge_pkg;

   localparam int REC_W = `MERGE_PAYLOAD_W + `MERGE_KEY_W;

   // payload sits in the upper half, key in the lower half
   typedef struct packed {
      logic [`MERGE_PAYLOAD_W-1:0] payload;
      logic [`MERGE_KEY_W-1:0]     key;
   } record_fields_t;

   // fifos store the raw word, compare logic looks at the fields
   typedef union packed {
      logic [REC_W-1:0] raw;
      record_fields_t   fields;
   } record_t;

   typedef enum logic [1:0] {
      MERGE,      // both runs open, pick the smaller head
      DRAIN_A,    // run on b ended, pass a through
      DRAIN_B,    // run on a ended, pass b through
      TERMINATE   // both runs ended, emit one zero record
   } merge_state_t;

endpackage

// File: design/record_fifo.sv
`timescale 1ns/100ps
`include "merge_macros.svh"

module record_fifo (
   input  logic                       i_clk,
   input  logic                       i_rst,
   input  logic                       i_wr,
   input  merge_pkg::record_t         i_wr_rec,
   input  logic                       i_rd,
   output merge_pkg::record_t         o_rd_rec,
   output logic                       o_empty,
   output logic                       o_full,
   output logic [`MERGE_COUNT_W-1:0]  o_count
);

   localparam int PTR_W = $clog2(`MERGE_FIFO_DEPTH);

   merge_pkg::record_t mem [`MERGE_FIFO_DEPTH];
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [`MERGE_COUNT_W-1:0] count;

   always_ff @(posedge i_clk) begin
      if (i_wr) begin
         mem[wr_ptr] <= i_wr_rec;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (i_wr) begin
            wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two, wraps by itself
         end
         if (i_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({i_wr, i_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // idle, or push and pop together
         endcase
      end
   end

   // show-ahead head
   assign o_rd_rec = mem[rd_ptr];
   assign o_empty  = (count == '0);
   assign o_full   = (count == `MERGE_COUNT_W'(`MERGE_FIFO_DEPTH));
   assign o_count  = count;

endmodule

// File: merger/merge_control.sv
`timescale 1ns/100ps
`include "merge_macros.svh"

module merge_control (
   input  logic                      i_clk,
   input  logic                      i_rst,
   input  logic                      i_a_empty,
   input  logic                      i_b_empty,
   input  logic                      i_a_term,
   input  logic                      i_b_term,
   input  logic                      i_a_lte_b,
   input  logic [`MERGE_COUNT_W-1:0] i_out_count,
   output logic                      o_take_a,
   output logic                      o_take_b,
   output logic                      o_take_term
);

   merge_pkg::merge_state_t state;
   merge_pkg::merge_state_t state_next;

   logic [`MERGE_PIPE_LAT-1:0] take_pipe;   // bit n set: take issued n+1 cycles ago
   logic [`MERGE_COUNT_W-1:0]  in_flight;
   logic [`MERGE_COUNT_W:0]    pending;
   logic                       credit;
   logic                       take_any;

   always_comb begin
      in_flight = '0;
      for (int i = 0; i < `MERGE_PIPE_LAT; i++) begin
         in_flight = in_flight + take_pipe[i];
      end
   end

   // records already in the output fifo plus those still in the datapath
   assign pending  = i_out_count + in_flight;
   assign credit   = (pending < `MERGE_FIFO_DEPTH);
   assign take_any = o_take_a | o_take_b | o_take_term;

   always_comb begin
      state_next  = state;
      o_take_a    = 1'b0;
      o_take_b    = 1'b0;
      o_take_term = 1'b0;
      case (state)
         merge_pkg::MERGE: begin
            if (!i_a_empty && !i_b_empty && i_a_term && i_b_term) begin
               state_next = merge_pkg::TERMINATE;
            end else if (!i_a_empty && i_a_term) begin
               state_next = merge_pkg::DRAIN_B;
            end else if (!i_b_empty && i_b_term) begin
               state_next = merge_pkg::DRAIN_A;
            end else if (!i_a_empty && !i_b_empty && credit) begin
               o_take_a = i_a_lte_b;   // ties go to a
               o_take_b = !i_a_lte_b;
            end
         end
         merge_pkg::DRAIN_A: begin
            if (!i_a_empty) begin
               if (i_a_term) begin
                  state_next = merge_pkg::TERMINATE;
               end else if (credit) begin
                  o_take_a = 1'b1;
               end
            end
         end
         merge_pkg::DRAIN_B: begin
            if (!i_b_empty) begin
               if (i_b_term) begin
                  state_next = merge_pkg::TERMINATE;
               end else if (credit) begin
                  o_take_b = 1'b1;
               end
            end
         end
         merge_pkg::TERMINATE: begin
            // both terminators sit at the heads here
            if (credit) begin
               o_take_term = 1'b1;
               state_next  = merge_pkg::MERGE;
            end
         end
         default: state_next = merge_pkg::MERGE;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state     <= merge_pkg::MERGE;
         take_pipe <= '0;
      end else begin
         state     <= state_next;
         take_pipe <= {take_pipe[`MERGE_PIPE_LAT-2:0], take_any};
      end
   end

endmodule

// File: merger/merge_datapath.sv
`timescale 1ns/100ps

module merge_datapath (
   input  logic               i_clk,
   input  logic               i_rst,
   input  merge_pkg::record_t i_a_head,
   input  merge_pkg::record_t i_b_head,
   input  logic               i_take_a,
   input  logic               i_take_b,
   input  logic               i_take_term,
   output logic               o_a_term,
   output logic               o_b_term,
   output logic               o_a_lte_b,
   output logic               o_wr,
   output merge_pkg::record_t o_wr_rec
);

   merge_pkg::record_t sel_rec;
   merge_pkg::record_t s1_rec;
   merge_pkg::record_t s2_rec;
   logic               s1_valid;
   logic               s2_valid;

   // a zero key closes a run
   assign o_a_term  = (i_a_head.fields.key == '0);
   assign o_b_term  = (i_b_head.fields.key == '0);
   assign o_a_lte_b = (i_a_head.fields.key <= i_b_head.fields.key);

   always_comb begin
      if (i_take_a) begin
         sel_rec = i_a_head;
      end else if (i_take_b) begin
         sel_rec = i_b_head;
      end else begin
         sel_rec.raw = '0;   // terminator record
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end else begin
         s1_valid <= i_take_a | i_take_b | i_take_term;
         s2_valid <= s1_valid;
      end
   end

   always_ff @(posedge i_clk) begin
      s1_rec <= sel_rec;
      s2_rec <= s1_rec;
   end

   assign o_wr     = s2_valid;
   assign o_wr_rec = s2_rec;

endmodule

// File: design/merge_unit.sv
`timescale 1ns/100ps
`include "merge_macros.svh"

module merge_unit (
   input  logic               i_clk,
   input  logic               i_rst,
   input  merge_pkg::record_t i_a_rec,
   input  merge_pkg::record_t i_b_rec,
   input  logic               i_a_empty,
   input  logic               i_b_empty,
   input  logic               i_out_ready,
   output logic               o_a_read,
   output logic               o_b_read,
   output logic               o_out_write,
   output merge_pkg::record_t o_out_rec
);

   merge_pkg::record_t a_head;
   merge_pkg::record_t b_head;
   merge_pkg::record_t pipe_rec;
   logic a_empty, a_full;
   logic b_empty, b_full;
   logic out_empty, out_full;
   logic [`MERGE_COUNT_W-1:0] out_count;
   logic take_a, take_b, take_term;
   logic a_term, b_term, a_lte_b;
   logic pipe_wr;
   logic out_ready_q;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         out_ready_q <= 1'b0;
      end else begin
         out_ready_q <= i_out_ready;   // ready from downstream, one cycle late
      end
   end

   assign o_a_read    = !i_a_empty && !a_full;
   assign o_b_read    = !i_b_empty && !b_full;
   assign o_out_write = out_ready_q && !out_empty;

   record_fifo a_fifo (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_wr     (o_a_read),
      .i_wr_rec (i_a_rec),
      .i_rd     (take_a | take_term),
      .o_rd_rec (a_head),
      .o_empty  (a_empty),
      .o_full   (a_full),
      .o_count  ()
   );

   record_fifo b_fifo (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_wr     (o_b_read),
      .i_wr_rec (i_b_rec),
      .i_rd     (take_b | take_term),
      .o_rd_rec (b_head),
      .o_empty  (b_empty),
      .o_full   (b_full),
      .o_count  ()
   );

   // never overflows, control holds takes back on its count
   record_fifo out_fifo (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_wr     (pipe_wr),
      .i_wr_rec (pipe_rec),
      .i_rd     (o_out_write),
      .o_rd_rec (o_out_rec),
      .o_empty  (out_empty),
      .o_full   (out_full),
      .o_count  (out_count)
   );

   merge_control u_control (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_a_empty   (a_empty),
      .i_b_empty   (b_empty),
      .i_a_term    (a_term),
      .i_b_term    (b_term),
      .i_a_lte_b   (a_lte_b),
      .i_out_count (out_count),
      .o_take_a    (take_a),
      .o_take_b    (take_b),
      .o_take_term (take_term)
   );

   merge_datapath u_datapath (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_a_head    (a_head),
      .i_b_head    (b_head),
      .i_take_a    (take_a),
      .i_take_b    (take_b),
      .i_take_term (take_term),
      .o_a_term    (a_term),
      .o_b_term    (b_term),
      .o_a_lte_b   (a_lte_b),
      .o_wr        (pipe_wr),
      .o_wr_rec    (pipe_rec)
   );

endmodule

// File: verif/merge_unit_checker.sv
`timescale 1ns/100ps

module merge_unit_checker (
   input logic i_clk,
   input logic i_rst,
   input logic i_out_push,
   input logic i_out_full,
   input logic i_a_pop,
   input logic i_a_empty,
   input logic i_b_pop,
   input logic i_b_empty,
   input logic i_out_write,
   input logic i_take_a,
   input logic i_take_b,
   input logic i_take_term
);

   int err_count = 0;   // polled by the testbench

   no_overflow: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_out_push && i_out_full))
      else begin
         $error("write to a full output fifo");
         err_count++;
      end

   no_underflow: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_a_pop && i_a_empty) && !(i_b_pop && i_b_empty))
      else begin
         $error("read from an empty record fifo");
         err_count++;
      end

   one_take: assert property (@(posedge i_clk) disable iff (i_rst)
      $onehot0({i_take_a, i_take_b, i_take_term}))
      else begin
         $error("more than one take in a cycle");
         err_count++;
      end

   // first edge of reset clears the ready register
   quiet_in_reset: assert property (@(posedge i_clk)
      i_rst && $past(i_rst) |-> !i_out_write)
      else begin
         $error("output write during reset");
         err_count++;
      end

endmodule

bind merge_unit merge_unit_checker u_checker (
   .i_clk       (i_clk),
   .i_rst       (i_rst),
   .i_out_push  (pipe_wr),
   .i_out_full  (out_full),
   .i_a_pop     (take_a | take_term),
   .i_a_empty   (a_empty),
   .i_b_pop     (take_b | take_term),
   .i_b_empty   (b_empty),
   .i_out_write (o_out_write),
   .i_take_a    (take_a),
   .i_take_b    (take_b),
   .i_take_term (take_term)
);

// File: verif/merge_unit_tb.sv
`timescale 1ns/100ps
`include "merge_macros.svh"

module merge_unit_tb;

   localparam int CLK_PERIOD = 20;
   localparam int N_PAIRS    = 40;
   localparam int TOTAL_W    = 16;
   // every pair fits in one fifo depth, allow 4 pipe latencies per record
   localparam int WATCHDOG_CYCLES = N_PAIRS * `MERGE_FIFO_DEPTH * 4 * `MERGE_PIPE_LAT;

   logic               i_clk;
   logic               i_rst;
   merge_pkg::record_t i_a_rec;
   merge_pkg::record_t i_b_rec;
   logic               i_a_empty;
   logic               i_b_empty;
   logic               i_out_ready;
   logic               o_a_read;
   logic               o_b_read;
   logic               o_out_write;
   merge_pkg::record_t o_out_rec;

   merge_pkg::record_t a_src[$];   // upstream fifo models
   merge_pkg::record_t b_src[$];
   merge_pkg::record_t exp_q[$];   // reference merge output
   logic [TOTAL_W-1:0] rx_count;
   logic               ready_q;    // ready as the dut registered it at the last edge
   logic [31:0]        rng_state = 32'h5340;

   merge_unit i_dut (.*);

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic merge_pkg::record_t make_record(input logic [`MERGE_KEY_W-1:0] key);
      merge_pkg::record_t r;
      r.fields.key     = key;
      r.fields.payload = next_rand();
      return r;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_record(input string name, input merge_pkg::record_t got,
                               input merge_pkg::record_t exp);
      if (got !== exp) begin
         abort_run($sformatf("Mismatch %s: got %h expected %h", name, got.raw, exp.raw));
      end
   endtask

   task automatic check_count(input string name, input logic [TOTAL_W-1:0] got,
                              input logic [TOTAL_W-1:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
      end
   endtask

   task automatic build_stimulus();
      merge_pkg::record_t ra[$];
      merge_pkg::record_t rb[$];
      merge_pkg::record_t zero_rec;
      logic [`MERGE_KEY_W-1:0] key;
      int len;
      int ia;
      int ib;
      zero_rec.raw = '0;
      for (int p = 0; p < N_PAIRS; p++) begin
         ra.delete();
         rb.delete();
         len = next_rand() % 8;
         key = 1 + next_rand() % 6;
         for (int i = 0; i < len; i++) begin
            ra.push_back(make_record(key));
            key = key + next_rand() % 3;   // repeats allowed
         end
         len = next_rand() % 8;
         key = 1 + next_rand() % 6;
         for (int i = 0; i < len; i++) begin
            rb.push_back(make_record(key));
            key = key + next_rand() % 3;
         end
         foreach (ra[i]) a_src.push_back(ra[i]);
         foreach (rb[i]) b_src.push_back(rb[i]);
         a_src.push_back(make_record('0));   // terminators carry junk payload
         b_src.push_back(make_record('0));
         ia = 0;
         ib = 0;
         while (ia < ra.size() || ib < rb.size()) begin
            if (ib == rb.size() ||
                (ia < ra.size() && ra[ia].fields.key <= rb[ib].fields.key)) begin
               exp_q.push_back(ra[ia]);   // a wins ties
               ia++;
            end else begin
               exp_q.push_back(rb[ib]);
               ib++;
            end
         end
         exp_q.push_back(zero_rec);
      end
   endtask

   task automatic drive_inputs();
      i_a_empty = (a_src.size() == 0) || (next_rand() % 4 == 0);
      i_b_empty = (b_src.size() == 0) || (next_rand() % 4 == 0);
      i_a_rec.raw = (a_src.size() != 0) ? a_src[0].raw : '0;
      i_b_rec.raw = (b_src.size() != 0) ? b_src[0].raw : '0;
      i_out_ready = (next_rand() % 3 != 0);
   endtask

   task automatic sample_outputs();
      // no pop of an empty upstream fifo, no write without registered ready
      if (i_a_empty) check_flag("o_a_read", o_a_read, 1'b0);
      if (i_b_empty) check_flag("o_b_read", o_b_read, 1'b0);
      if (!ready_q) check_flag("o_out_write", o_out_write, 1'b0);
      ready_q = i_out_ready;
      if (o_a_read) void'(a_src.pop_front());
      if (o_b_read) void'(b_src.pop_front());
      if (o_out_write) begin
         rx_count = rx_count + 1'b1;   // extra writes show up in the final count
         if (exp_q.size() != 0) begin
            check_record("o_out_rec", o_out_rec, exp_q.pop_front());
         end
      end
   endtask

   initial begin : clock_gen
      i_clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) i_clk = ~i_clk;
      end
   end

   initial begin : watchdog
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      abort_run("output stalled, not all expected records arrived in time");
   end

   initial begin : stimulus
      int exp_total;
      i_rst       = 1'b1;
      i_a_rec.raw = '0;
      i_b_rec.raw = '0;
      i_a_empty   = 1'b1;
      i_b_empty   = 1'b1;
      i_out_ready = 1'b1;   // ready high in reset, the write must still stay low
      rx_count    = '0;
      ready_q     = 1'b0;
      build_stimulus();
      exp_total = exp_q.size();
      repeat (3) begin
         @(negedge i_clk);
         check_flag("o_out_write", o_out_write, 1'b0);
      end
      i_rst = 1'b0;
      while (exp_q.size() != 0) begin
         drive_inputs();
         @(posedge i_clk);
         sample_outputs();
         @(negedge i_clk);
         if (i_dut.u_checker.err_count != 0) abort_run("a bound assertion failed");
      end
      // quiet window with ready high, a stray write would show up here
      i_a_empty   = 1'b1;
      i_b_empty   = 1'b1;
      i_out_ready = 1'b1;
      repeat (4 * `MERGE_PIPE_LAT) begin
         @(posedge i_clk);
         sample_outputs();
      end
      check_count("record count", rx_count, TOTAL_W'(exp_total));
      check_count("a_src left", TOTAL_W'(a_src.size()), '0);
      check_count("b_src left", TOTAL_W'(b_src.size()), '0);
      if (i_dut.u_checker.err_count != 0) begin
         abort_run("a bound assertion failed");
      end else begin
         $display("TESTS PASSED");
         $finish;
      end
   end

endmodule

// File: merge_unit.f
+incdir+common
common/merge_pkg.sv
design/record_fifo.sv
merger/merge_control.sv
merger/merge_datapath.sv
design/merge_unit.sv
verif/merge_unit_checker.sv
verif/merge_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the merge unit testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module merge_unit_tb \
   -f merge_unit.f \
   -o merge_unit_sim

# the log decides the result, so a nonzero exit of the run is tolerated here
./obj_dir/merge_unit_sim +verilator+error+limit+100 > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG" || ! grep -q "TESTS PASSED" "$LOG"; then
   echo "simulation failed, see $LOG"
   exit 1
fi
echo "simulation passed"
